// File: files.f
+incdir+tests
logic/rv_isa_pkg.sv
logic/exec_pkg.sv
logic/decode_if.sv
logic/mul_if.sv
logic/instr_decoder.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/mul_unit.sv
logic/retire_ctrl.sv
logic/exec_top.sv
tests/exec_tb.sv

// File: logic/branch_unit.sv
`timescale 1ns/10ps

module branch_unit import rv_isa_pkg::*, exec_pkg::*; (
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    decode_if.user          dec,
    output logic            taken,
    output logic [XLEN-1:0] target
);

    logic            cond;
    logic [XLEN-1:0] jalr_sum;

    always_comb begin
        case (dec.funct3)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  cond = (rs1_data < rs2_data);
            3'b111:  cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.op_class)
            CLS_BRANCH:        taken = cond;
            CLS_JAL, CLS_JALR: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    // Jalr target has bit 0 cleared
    assign jalr_sum = rs1_data + dec.imm;
    assign target   = (dec.op_class == CLS_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc + dec.imm;

endmodule

// File: logic/decode_if.sv
`timescale 1ns/10ps

interface decode_if import rv_isa_pkg::*, exec_pkg::*; ();

    op_class_e       op_class;
    logic [2:0]      funct3;
    logic            alt;
    logic [XLEN-1:0] imm;
    logic            is_imm;
    mul_kind_e       mul_kind;
    logic [4:0]      rd;

    modport dec (
        output op_class, funct3, alt, imm, is_imm, mul_kind, rd
    );

    // Read side for the ALU, branch unit and retire control
    modport user (
        input op_class, funct3, alt, imm, is_imm, mul_kind, rd
    );

endinterface

// File: logic/exec_pkg.sv
package exec_pkg;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_LUI,
        CLS_AUIPC,
        CLS_MUL,
        CLS_ILLEGAL
    } op_class_e;

    typedef enum logic [2:0] {
        WB_ALU,
        WB_PC_PLUS_4,
        WB_UPPER_IMM,
        WB_AUIPC_SUM,
        WB_MUL_LOW,
        WB_MUL_HIGH
    } wb_sel_e;

    // Encoded as funct3[1:0] of the multiply instructions
    typedef enum logic [1:0] {
        MK_MUL,
        MK_MULH,
        MK_MULHSU,
        MK_MULHU
    } mul_kind_e;

    localparam int MUL_BITS_PER_CYCLE_DEFAULT = 4;

endpackage

// File: logic/exec_top.sv
`timescale 1ns/10ps

module exec_top import rv_isa_pkg::*, exec_pkg::*; #(
    parameter int MUL_BITS_PER_CYCLE = MUL_BITS_PER_CYCLE_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [XLEN-1:0] instr,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic            instr_ready,
    output logic [4:0]      rd_addr,
    output logic [XLEN-1:0] rd_wdata,
    output logic            rd_write,
    output logic            branch_taken,
    output logic [XLEN-1:0] branch_target,
    output logic            illegal
);

    logic [XLEN-1:0] alu_result;
    logic            br_taken;
    logic [XLEN-1:0] br_target;

    decode_if dec_bus ();
    mul_if    mul_bus ();

    instr_decoder decoder (
        .instr (instr),
        .dec   (dec_bus)
    );

    int_alu alu (
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec_bus),
        .result   (alu_result)
    );

    branch_unit branch (
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec_bus),
        .taken    (br_taken),
        .target   (br_target)
    );

    mul_unit #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) multiplier (
        .clk   (clk),
        .rst_n (rst_n),
        .mul   (mul_bus)
    );

    retire_ctrl retire (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .dec         (dec_bus),
        .mul         (mul_bus),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .instr_ready (instr_ready),
        .rd_addr     (rd_addr),
        .rd_wdata    (rd_wdata),
        .rd_write    (rd_write)
    );

    assign branch_taken  = instr_valid && br_taken;
    assign branch_target = instr_valid ? br_target : '0;
    assign illegal       = instr_valid && (dec_bus.op_class == CLS_ILLEGAL);

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder import rv_isa_pkg::*, exec_pkg::*; (
    input instr_t instr,
    decode_if.dec dec
);

    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;

    assign opcode = instr.r_fmt.opcode;
    assign funct7 = instr.r_fmt.funct7;
    assign funct3 = instr.r_fmt.funct3;

    assign imm_i = {{(XLEN-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
    assign imm_u = {instr.u_fmt.imm20, 12'h000};
    assign imm_b = {{(XLEN-12){funct7[6]}}, instr.r_fmt.rd[0], funct7[5:0],
                    instr.r_fmt.rd[4:1], 1'b0};
    // J immediate bits are scattered over the U field
    assign imm_j = {{(XLEN-20){instr.u_fmt.imm20[19]}}, instr.u_fmt.imm20[7:0],
                    instr.u_fmt.imm20[8], instr.u_fmt.imm20[18:9], 1'b0};

    always_comb begin
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0) begin
                    dec.op_class = CLS_ALU;
                end else if (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    dec.op_class = CLS_ALU;
                end else if (funct7 == FUNCT7_MULDIV && !funct3[2]) begin
                    dec.op_class = CLS_MUL;
                end else begin
                    // Divide and remainder land here too
                    dec.op_class = CLS_ILLEGAL;
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001 && funct7 != 7'b0) begin
                    dec.op_class = CLS_ILLEGAL;
                end else if (funct3 == 3'b101 && funct7 != 7'b0 && funct7 != FUNCT7_ALT) begin
                    dec.op_class = CLS_ILLEGAL;
                end else begin
                    dec.op_class = CLS_ALU;
                end
            end
            OPC_BRANCH: begin
                dec.op_class = (funct3[2:1] == 2'b01) ? CLS_ILLEGAL : CLS_BRANCH;
            end
            OPC_JAL:   dec.op_class = CLS_JAL;
            OPC_JALR:  dec.op_class = (funct3 == 3'b000) ? CLS_JALR : CLS_ILLEGAL;
            OPC_LUI:   dec.op_class = CLS_LUI;
            OPC_AUIPC: dec.op_class = CLS_AUIPC;
            default:   dec.op_class = CLS_ILLEGAL;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_BRANCH:           dec.imm = imm_b;
            OPC_JAL:              dec.imm = imm_j;
            OPC_LUI, OPC_AUIPC:   dec.imm = imm_u;
            default:              dec.imm = imm_i;
        endcase
    end

    assign dec.funct3   = funct3;
    assign dec.alt      = funct7[5];
    assign dec.is_imm   = (opcode == OPC_OP_IMM);
    assign dec.mul_kind = mul_kind_e'(funct3[1:0]);
    assign dec.rd       = instr.r_fmt.rd;

endmodule

// File: logic/int_alu.sv
`timescale 1ns/10ps

module int_alu import rv_isa_pkg::*; (
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    decode_if.user          dec,
    output logic [XLEN-1:0] result
);

    localparam int SHW = $clog2(XLEN);

    logic [XLEN-1:0] op_b;
    logic [SHW-1:0]  shamt;

    assign op_b  = dec.is_imm ? dec.imm : rs2_data;
    assign shamt = op_b[SHW-1:0];

    always_comb begin
        case (dec.funct3)
            3'b000: begin
                // Immediate form has no subtract
                if (dec.alt && !dec.is_imm) begin
                    result = rs1_data - op_b;
                end else begin
                    result = rs1_data + op_b;
                end
            end
            3'b001: result = rs1_data << shamt;
            3'b010: result = {{(XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            3'b011: result = {{(XLEN-1){1'b0}}, rs1_data < op_b};
            3'b100: result = rs1_data ^ op_b;
            3'b101: begin
                if (dec.alt) begin
                    result = $signed(rs1_data) >>> shamt;
                end else begin
                    result = rs1_data >> shamt;
                end
            end
            3'b110: result = rs1_data | op_b;
            default: result = rs1_data & op_b;
        endcase
    end

endmodule

// File: logic/mul_if.sv
`timescale 1ns/10ps

interface mul_if import rv_isa_pkg::*, exec_pkg::*; ();

    logic            start;
    mul_kind_e       kind;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            busy;
    logic            done;
    logic [63:0]     product;

    modport req  (output start, kind, a, b, input busy, done, product);

    // Start only taken while busy is low
    modport unit (input start, kind, a, b, output busy, done, product);

endinterface

// File: logic/mul_unit.sv
`timescale 1ns/10ps

module mul_unit import rv_isa_pkg::*, exec_pkg::*; #(
    parameter int MUL_BITS_PER_CYCLE = MUL_BITS_PER_CYCLE_DEFAULT
) (
    input logic  clk,
    input logic  rst_n,
    mul_if.unit  mul
);

    localparam int STEPS = XLEN / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic              busy;
    logic              done;
    logic [CNT_W-1:0]  count;
    logic              last_step;
    logic              take;
    logic              neg_in;
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;
    logic [2*XLEN-1:0] ma;
    logic [XLEN-1:0]   mb;
    logic [2*XLEN-1:0] acc;
    logic [2*XLEN-1:0] partial;
    logic [2*XLEN-1:0] acc_next;
    logic              neg;
    logic [63:0]       product;

    assign take      = mul.start && !busy;
    assign last_step = (count == CNT_W'(STEPS - 1));

    // Magnitudes for the unsigned core, sign restored at the end
    always_comb begin
        mag_a  = mul.a;
        mag_b  = mul.b;
        neg_in = 1'b0;
        case (mul.kind)
            MK_MUL, MK_MULH: begin
                mag_a  = mul.a[XLEN-1] ? -mul.a : mul.a;
                mag_b  = mul.b[XLEN-1] ? -mul.b : mul.b;
                neg_in = mul.a[XLEN-1] ^ mul.b[XLEN-1];
            end
            MK_MULHSU: begin
                mag_a  = mul.a[XLEN-1] ? -mul.a : mul.a;
                neg_in = mul.a[XLEN-1];
            end
            default: neg_in = 1'b0;
        endcase
    end

    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (mb[i]) begin
                partial = partial + (ma << i);
            end
        end
    end

    assign acc_next = acc + partial;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (take) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ma  <= {{XLEN{1'b0}}, mag_a};
            mb  <= mag_b;
            acc <= '0;
            neg <= neg_in;
        end else if (busy) begin
            ma  <= ma << MUL_BITS_PER_CYCLE;
            mb  <= mb >> MUL_BITS_PER_CYCLE;
            acc <= acc_next;
            // Held until the next start
            if (last_step) begin
                product <= neg ? -acc_next : acc_next;
            end
        end
    end

    assign mul.busy    = busy;
    assign mul.done    = done;
    assign mul.product = product;

endmodule

// File: logic/retire_ctrl.sv
`timescale 1ns/10ps

module retire_ctrl import rv_isa_pkg::*, exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    decode_if.user          dec,
    mul_if.req              mul,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] alu_result,
    output logic            instr_ready,
    output logic [4:0]      rd_addr,
    output logic [XLEN-1:0] rd_wdata,
    output logic            rd_write
);

    logic    is_mul;
    logic    mul_started;
    logic    writes_reg;
    wb_sel_e wb_sel;

    assign is_mul = (dec.op_class == CLS_MUL);

    // One start per multiply, first valid cycle only
    assign mul.start = instr_valid && is_mul && !mul_started && !mul.busy;
    assign mul.kind  = dec.mul_kind;
    assign mul.a     = rs1_data;
    assign mul.b     = rs2_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_started <= 1'b0;
        end else if (mul.done) begin
            mul_started <= 1'b0;
        end else if (mul.start) begin
            mul_started <= 1'b1;
        end
    end

    assign instr_ready = instr_valid && (!is_mul || mul.done);

    always_comb begin
        writes_reg = 1'b1;
        case (dec.op_class)
            CLS_ALU:           wb_sel = WB_ALU;
            CLS_JAL, CLS_JALR: wb_sel = WB_PC_PLUS_4;
            CLS_LUI:           wb_sel = WB_UPPER_IMM;
            CLS_AUIPC:         wb_sel = WB_AUIPC_SUM;
            CLS_MUL:           wb_sel = (dec.mul_kind == MK_MUL) ? WB_MUL_LOW : WB_MUL_HIGH;
            default: begin
                wb_sel     = WB_ALU;
                writes_reg = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_PC_PLUS_4: rd_wdata = pc + XLEN'(4);
            WB_UPPER_IMM: rd_wdata = dec.imm;
            WB_AUIPC_SUM: rd_wdata = pc + dec.imm;
            WB_MUL_LOW:   rd_wdata = mul.product[XLEN-1:0];
            WB_MUL_HIGH:  rd_wdata = mul.product[2*XLEN-1:XLEN];
            default:      rd_wdata = alu_result;
        endcase
    end

    // x0 is never written
    assign rd_addr  = dec.rd;
    assign rd_write = instr_valid && instr_ready && writes_reg && (dec.rd != 5'd0);

endmodule

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN = 32;

    // Major opcodes handled by the execute stage
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
    // Selects sub and sra
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // Same instruction word, viewed per encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } instr_t;

endpackage

// File: tests/exec_cases.svh
// Columns: instr, pc, rs1, rs2, expected wdata, write, taken, target, illegal
// Target is compared only on rows where taken is expected
task automatic load_directed_cases();
    // Register ALU ops
    add_case(enc_r(7'h00, 3'd0, 5'd5), 32'h100, 32'h5, 32'h7, 32'hc, 1, 0, 0, 0);
    add_case(enc_r(7'h20, 3'd0, 5'd5), 32'h100, 32'h5, 32'h7, 32'hffff_fffe, 1, 0, 0, 0);
    add_case(enc_r(7'h00, 3'd2, 5'd5), 32'h100, 32'hffff_ffff, 32'h1, 32'h1, 1, 0, 0, 0);
    add_case(enc_r(7'h00, 3'd3, 5'd5), 32'h100, 32'hffff_ffff, 32'h1, 32'h0, 1, 0, 0, 0);
    add_case(enc_r(7'h00, 3'd7, 5'd6), 32'h100, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200,
             1, 0, 0, 0);
    add_case(enc_r(7'h00, 3'd6, 5'd6), 32'h100, 32'hf000_0000, 32'hf, 32'hf000_000f, 1, 0, 0, 0);
    add_case(enc_r(7'h00, 3'd4, 5'd6), 32'h100, 32'haaaa_5555, 32'hffff_0000, 32'h5555_5555,
             1, 0, 0, 0);
    // Shift amount uses the low five bits only
    add_case(enc_r(7'h00, 3'd1, 5'd7), 32'h100, 32'h1, 32'h24, 32'h10, 1, 0, 0, 0);
    add_case(enc_r(7'h00, 3'd5, 5'd7), 32'h100, 32'h8000_0000, 32'h4, 32'h0800_0000, 1, 0, 0, 0);
    add_case(enc_r(7'h20, 3'd5, 5'd7), 32'h100, 32'h8000_0000, 32'h4, 32'hf800_0000, 1, 0, 0, 0);
    add_case(enc_r(7'h00, 3'd0, 5'd0), 32'h100, 32'h5, 32'h7, 32'h0, 0, 0, 0, 0);

    // Immediate ALU ops
    add_case(enc_i(12'hfff, 3'd0, 5'd8, OPC_I), 32'h100, 32'ha, 32'h1234_5678, 32'h9, 1, 0, 0, 0);
    add_case(enc_i(12'h400, 3'd0, 5'd8, OPC_I), 32'h100, 32'h1, 32'h1000, 32'h401, 1, 0, 0, 0);
    add_case(enc_i(12'hffe, 3'd2, 5'd8, OPC_I), 32'h100, 32'hffff_fffd, 32'h0, 32'h1, 1, 0, 0, 0);
    add_case(enc_i(12'hfff, 3'd3, 5'd8, OPC_I), 32'h100, 32'h5, 32'h0, 32'h1, 1, 0, 0, 0);
    add_case(enc_i(12'hff0, 3'd7, 5'd8, OPC_I), 32'h100, 32'h1234_5678, 32'h0, 32'h1234_5670,
             1, 0, 0, 0);
    add_case(enc_i(12'h0f0, 3'd6, 5'd8, OPC_I), 32'h100, 32'h0f00, 32'h0, 32'h0ff0, 1, 0, 0, 0);
    add_case(enc_i(12'hfff, 3'd4, 5'd8, OPC_I), 32'h100, 32'hffff, 32'h0, 32'hffff_0000, 1, 0, 0, 0);
    add_case(enc_i(12'h003, 3'd1, 5'd8, OPC_I), 32'h100, 32'h11, 32'h0, 32'h88, 1, 0, 0, 0);
    add_case(enc_i(12'h008, 3'd5, 5'd8, OPC_I), 32'h100, 32'hff00_0000, 32'h0, 32'h00ff_0000,
             1, 0, 0, 0);
    add_case(enc_i(12'h408, 3'd5, 5'd8, OPC_I), 32'h100, 32'hff00_0000, 32'h0, 32'hffff_0000,
             1, 0, 0, 0);

    // Conditional branches
    add_case(enc_b(13'h0010, 3'd0), 32'h200, 32'h3, 32'h3, 32'h0, 0, 1, 32'h210, 0);
    add_case(enc_b(13'h0010, 3'd0), 32'h200, 32'h3, 32'h4, 32'h0, 0, 0, 0, 0);
    add_case(enc_b(13'h1ff8, 3'd1), 32'h200, 32'h1, 32'h2, 32'h0, 0, 1, 32'h1f8, 0);
    add_case(enc_b(13'h0020, 3'd4), 32'h200, 32'hffff_ffff, 32'h1, 32'h0, 0, 1, 32'h220, 0);
    add_case(enc_b(13'h0020, 3'd5), 32'h200, 32'hffff_ffff, 32'h1, 32'h0, 0, 0, 0, 0);
    add_case(enc_b(13'h0004, 3'd5), 32'h200, 32'h7, 32'h7, 32'h0, 0, 1, 32'h204, 0);
    add_case(enc_b(13'h0020, 3'd6), 32'h200, 32'hffff_ffff, 32'h1, 32'h0, 0, 0, 0, 0);
    add_case(enc_b(13'h0800, 3'd7), 32'h200, 32'hffff_ffff, 32'h1, 32'h0, 0, 1, 32'ha00, 0);

    // Jumps
    add_case(enc_j(21'h001000, 5'd1), 32'h300, 32'h0, 32'h0, 32'h304, 1, 1, 32'h1300, 0);
    add_case(enc_j(21'h1ffffc, 5'd0), 32'h300, 32'h0, 32'h0, 32'h304, 0, 1, 32'h2fc, 0);
    add_case(enc_i(12'h007, 3'd0, 5'd1, OPC_JALR), 32'h400, 32'h1000, 32'h0, 32'h404,
             1, 1, 32'h1006, 0);
    add_case(enc_i(12'hfff, 3'd0, 5'd9, OPC_JALR), 32'h400, 32'h2000, 32'h0, 32'h404,
             1, 1, 32'h1ffe, 0);

    // Upper immediates
    add_case(enc_u(20'h12345, 5'd3, OPC_LUI), 32'h500, 32'h0, 32'h0, 32'h1234_5000, 1, 0, 0, 0);
    add_case(enc_u(20'h12345, 5'd0, OPC_LUI), 32'h500, 32'h0, 32'h0, 32'h0, 0, 0, 0, 0);
    add_case(enc_u(20'h00010, 5'd4, OPC_AUIPC), 32'h1000, 32'h0, 32'h0, 32'h11000, 1, 0, 0, 0);
    add_case(enc_u(20'hfffff, 5'd4, OPC_AUIPC), 32'h2000, 32'h0, 32'h0, 32'h1000, 1, 0, 0, 0);

    // Multiply corner cases
    add_case(enc_r(7'h01, 3'd0, 5'd10), 32'h600, 32'hffff_ffff, 32'hffff_ffff, 32'h1, 1, 0, 0, 0);
    add_case(enc_r(7'h01, 3'd1, 5'd10), 32'h600, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 1, 0, 0, 0);
    add_case(enc_r(7'h01, 3'd1, 5'd10), 32'h600, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000,
             1, 0, 0, 0);
    add_case(enc_r(7'h01, 3'd2, 5'd10), 32'h600, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
             1, 0, 0, 0);
    add_case(enc_r(7'h01, 3'd2, 5'd10), 32'h600, 32'h2, 32'h8000_0000, 32'h1, 1, 0, 0, 0);
    add_case(enc_r(7'h01, 3'd3, 5'd10), 32'h600, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe,
             1, 0, 0, 0);
    add_case(enc_r(7'h01, 3'd0, 5'd10), 32'h600, 32'h8000_0000, 32'h7fff_ffff, 32'h8000_0000,
             1, 0, 0, 0);
    add_case(enc_r(7'h01, 3'd1, 5'd10), 32'h600, 32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000,
             1, 0, 0, 0);
    add_case(enc_r(7'h01, 3'd0, 5'd0), 32'h600, 32'h3, 32'h5, 32'h0, 0, 0, 0, 0);

    // Illegal encodings, divide included
    add_case(enc_i(12'h000, 3'd0, 5'd5, 7'h0b), 32'h700, 32'h0, 32'h0, 32'h0, 0, 0, 0, 1);
    add_case(enc_i(12'h004, 3'd2, 5'd5, OPC_LOAD), 32'h700, 32'h0, 32'h0, 32'h0, 0, 0, 0, 1);
    add_case(enc_r(7'h10, 3'd0, 5'd5), 32'h700, 32'h1, 32'h2, 32'h0, 0, 0, 0, 1);
    add_case(enc_r(7'h01, 3'd4, 5'd5), 32'h700, 32'h6, 32'h3, 32'h0, 0, 0, 0, 1);
    add_case(enc_i(12'h000, 3'd1, 5'd5, OPC_JALR), 32'h700, 32'h0, 32'h0, 32'h0, 0, 0, 0, 1);
    add_case(enc_b(13'h0010, 3'd2), 32'h700, 32'h1, 32'h1, 32'h0, 0, 0, 0, 1);
endtask

// File: tests/exec_tb.sv
`timescale 1ns/10ps

module exec_tb;

    localparam int XLEN       = 32;
    localparam int NUM_RANDOM = 20;

    localparam logic [6:0] OPC_R     = 7'h33;
    localparam logic [6:0] OPC_I     = 7'h13;
    localparam logic [6:0] OPC_B     = 7'h63;
    localparam logic [6:0] OPC_JAL   = 7'h6f;
    localparam logic [6:0] OPC_JALR  = 7'h67;
    localparam logic [6:0] OPC_LUI   = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;
    localparam logic [6:0] OPC_LOAD  = 7'h03;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] wdata;
        logic        write;
        logic        taken;
        logic [31:0] target;
        logic        illegal;
    } case_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        instr_ready;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    logic        rd_write;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        illegal;

    case_t cases[$];
    int    seed;
    int    cycle_count = 0;
    int    cycle_limit = 0;
    int    row_errors;
    int    failed_tests;
    int    gap_errors;

    exec_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .instr_ready   (instr_ready),
        .rd_addr       (rd_addr),
        .rd_wdata      (rd_wdata),
        .rd_write      (rd_write),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .illegal       (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog armed once the table size is known
    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
                $display("Timeout after %0d cycles, the DUT never became ready", cycle_count);
                $display("Verification failed");
                $finish;
            end
        end
    end

    // Encoders use rs1 = x1 and rs2 = x2
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, OPC_R};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_B};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // Product modulo 2^64 from sign or zero extended operands
    function automatic logic [31:0] expected_mul(input logic [1:0] kind, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [63:0] ext_a;
        logic [63:0] ext_b;
        logic [63:0] prod;
        ext_a = (kind == 2'd3) ? {32'b0, a} : {{32{a[31]}}, a};
        ext_b = (kind == 2'd0 || kind == 2'd1) ? {{32{b[31]}}, b} : {32'b0, b};
        prod  = ext_a * ext_b;
        return (kind == 2'd0) ? prod[31:0] : prod[63:32];
    endfunction

    // Multiply encodings are the only multi-cycle ones
    function automatic logic is_multiply(input logic [31:0] word);
        return (word[6:0] == OPC_R) && (word[31:25] == 7'h01) && !word[14];
    endfunction

    task automatic add_case(input logic [31:0] word, input logic [31:0] pc_v,
                            input logic [31:0] rs1_v, input logic [31:0] rs2_v,
                            input logic [31:0] wdata_v, input logic write_v,
                            input logic taken_v, input logic [31:0] target_v,
                            input logic illegal_v);
        case_t c;
        c.instr   = word;
        c.pc      = pc_v;
        c.rs1     = rs1_v;
        c.rs2     = rs2_v;
        c.wdata   = wdata_v;
        c.write   = write_v;
        c.taken   = taken_v;
        c.target  = target_v;
        c.illegal = illegal_v;
        cases.push_back(c);
    endtask

    `include "exec_cases.svh"

    task automatic add_random_mul_cases();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        int          n;
        for (n = 0; n < NUM_RANDOM; n++) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            add_case(enc_r(7'h01, {1'b0, r[1:0]}, 5'd11), 32'h800, a, b,
                     expected_mul(r[1:0], a, b), 1, 0, 0, 0);
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s expected %0h, got %0h", name, exp, got);
            row_errors++;
        end
    endtask

    task automatic apply_case(input int idx);
        case_t c;
        int    waited;
        c = cases[idx];
        row_errors = 0;
        waited = 0;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= c.instr;
        pc          <= c.pc;
        rs1_data    <= c.rs1;
        rs2_data    <= c.rs2;
        @(negedge clk);
        while (instr_ready !== 1'b1) begin
            @(negedge clk);
            waited++;
        end
        // Everything but a multiply is accepted in its first valid cycle
        if (!is_multiply(c.instr)) begin
            assert (waited == 0) else begin
                $display("Test %0d was not accepted in its first valid cycle, waited %0d cycles",
                         idx, waited);
                row_errors++;
            end
        end
        compare("illegal", illegal, c.illegal);
        compare("rd_write", rd_write, c.write);
        compare("branch_taken", branch_taken, c.taken);
        if (c.write) begin
            compare("rd_wdata", rd_wdata, c.wdata);
            compare("rd_addr", rd_addr, c.instr[11:7]);
        end
        if (c.taken) begin
            compare("branch_target", branch_target, c.target);
        end
        if (row_errors == 0) begin
            $display("Test %0d instr %h ok", idx, c.instr);
        end else begin
            $display("Test %0d instr %h failed with %0d mismatches", idx, c.instr, row_errors);
            failed_tests++;
        end
    endtask

    // Valid low with a scrambled instruction word on the bus
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            instr       <= $random(seed);
            @(negedge clk);
            row_errors = 0;
            compare("rd_write", rd_write, 1'b0);
            compare("instr_ready", instr_ready, 1'b0);
            gap_errors += row_errors;
        end
    endtask

    initial begin
        int idx;
        seed         = 86;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        failed_tests = 0;
        gap_errors   = 0;
        load_directed_cases();
        add_random_mul_cases();
        cycle_limit = cases.size() * (XLEN / 4 + 4) + 50;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (idx = 0; idx < cases.size(); idx++) begin
            apply_case(idx);
            idle_cycles({$random(seed)} % 3);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        $display("%0d tests run, %0d failed, %0d idle cycle mismatches",
                 cases.size(), failed_tests, gap_errors);
        if (failed_tests == 0 && gap_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
